// ==== tb.f ====
logic/cpuPkg.sv
logic/creditQueue.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/statusFlags.sv
logic/execCore.sv
verif/execCoreAsserts.sv
verif/execCoreTb.sv

// ==== verif/execCoreTb.sv ====
`default_nettype none

module execCoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  import cpuPkg::*;

  localparam int InDepth = 4;
  localparam int OutCredits = 2;
  localparam int WaitLimit = 300;

  logic clk = 1'b0;
  logic reset;
  logic inValid;
  wordT inWord;
  logic inCreditReturn;
  logic outValid;
  wordT outWord;
  logic outCreditReturn = 1'b0;
  wordT inPort;
  logic branchValid;
  wordT branchTarget;
  logic illegalOp;

  integer seed = 32'h806e31d1;
  int errorCount = 0;
  int checkCount = 0;
  int wordsSent = 0;
  int creditsBack = 0;
  int illegalCount = 0;
  int owedCredits = 0;
  logic holdCredits = 1'b0;
  wordT outSeen[$];
  wordT outExp[$];
  wordT branchSeen[$];
  wordT branchExp[$];

  execCore #(.InDepth(InDepth), .OutCredits(OutCredits)) execCore_inst (
    .clk, .reset, .inValid, .inWord, .inCreditReturn,
    .outValid, .outWord, .outCreditReturn, .inPort,
    .branchValid, .branchTarget, .illegalOp
  );

  bind execCore execCoreAsserts #(.OutCredits(OutCredits)) execCoreAsserts_inst (
    .clk, .reset, .outCreditCount, .outValid, .outCreditReturn,
    .branchValid, .illegalOp
  );

  always #4 clk = ~clk;

  // Consumer model and output monitor
  always @(negedge clk) begin
    if (!reset) begin
      if (outValid) begin
        outSeen.push_back(outWord);
        owedCredits++;
      end
      if (branchValid) begin
        branchSeen.push_back(branchTarget);
      end
      if (illegalOp) begin
        illegalCount++;
      end
      if (inCreditReturn) begin
        creditsBack++;
      end
    end
    if (!holdCredits && owedCredits > 0) begin
      outCreditReturn = 1'b1;
      owedCredits--;
    end else begin
      outCreditReturn = 1'b0;
    end
  end

  function automatic wordT encode(opCodeT op, regIdxT rd, regIdxT rs, logic [4:0] sh);
    return {op, rd, rs, sh};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic closeRun();
    $display("Closing report: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout: %s", what);
    errorCount++;
  endtask

  // Fetcher model sends one word per call while it holds a credit
  task automatic sendWord(input wordT w);
    int cycles;
    cycles = 0;
    while (wordsSent - creditsBack >= InDepth && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (wordsSent - creditsBack >= InDepth) begin
      reportTimeout("the fetcher never got an input credit back");
    end else begin
      inValid = 1'b1;
      inWord = w;
      wordsSent++;
      @(negedge clk);
      inValid = 1'b0;
    end
  endtask

  task automatic sendInstr(input opCodeT op, input regIdxT rd, input regIdxT rs,
                           input logic [4:0] sh);
    sendWord(encode(op, rd, rs, sh));
  endtask

  task automatic loadReg(input regIdxT idx, input wordT value);
    sendInstr(opLdm, idx, 3'd0, 5'd0);
    sendWord(value);
  endtask

  task automatic outReg(input regIdxT idx, input wordT expected);
    sendInstr(opOut, idx, 3'd0, 5'd0);
    outExp.push_back(expected);
  endtask

  task automatic waitForOutCount(input int count);
    int cycles;
    cycles = 0;
    while (outSeen.size() < count && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (outSeen.size() < count) begin
      reportTimeout("expected outValid pulses did not arrive");
    end
  endtask

  task automatic collectOutputs();
    waitForOutCount(outExp.size());
    checkValue("outValid pulse count", outSeen.size(), outExp.size());
    foreach (outExp[i]) begin
      checkValue($sformatf("outWord[%0d]", i), outSeen[i], outExp[i]);
    end
    outSeen.delete();
    outExp.delete();
  endtask

  task automatic compareBranches();
    checkValue("branchValid pulse count", branchSeen.size(), branchExp.size());
    if (branchSeen.size() == branchExp.size()) begin
      foreach (branchExp[i]) begin
        checkValue($sformatf("branchTarget[%0d]", i), branchSeen[i], branchExp[i]);
      end
    end
    branchSeen.delete();
    branchExp.delete();
  endtask

  task automatic ldmOutTest();
    loadReg(3'd1, 16'h1234);
    loadReg(3'd2, 16'hbeef);
    outReg(3'd1, 16'h1234);
    outReg(3'd2, 16'hbeef);
    collectOutputs();
  endtask

  task automatic aluTest();
    wordT a;
    wordT b;
    wordT c;
    wordT d;
    wordT r;
    logic [3:0] shA;
    logic [3:0] shB;
    for (int pass = 0; pass < 2; pass++) begin
      a = wordT'($random(seed));
      b = wordT'($random(seed));
      c = wordT'($random(seed));
      d = wordT'($random(seed));
      shA = 4'($random(seed));
      shB = 4'($random(seed));
      loadReg(3'd3, a);
      loadReg(3'd4, b);
      r = a;
      // Each OUT reads R3 right behind the instruction that writes it
      sendInstr(opAdd, 3'd3, 3'd4, 5'd0);
      r = r + b;
      outReg(3'd3, r);
      sendInstr(opNot, 3'd3, 3'd0, 5'd0);
      r = ~r;
      outReg(3'd3, r);
      sendInstr(opSub, 3'd3, 3'd4, 5'd0);
      r = r - b;
      outReg(3'd3, r);
      sendInstr(opAnd, 3'd3, 3'd4, 5'd0);
      r = r & b;
      outReg(3'd3, r);
      sendInstr(opInc, 3'd3, 3'd0, 5'd0);
      r = r + 16'd1;
      outReg(3'd3, r);
      sendInstr(opOr, 3'd3, 3'd4, 5'd0);
      r = r | b;
      outReg(3'd3, r);
      sendInstr(opDec, 3'd3, 3'd0, 5'd0);
      r = r - 16'd1;
      outReg(3'd3, r);
      sendInstr(opShl, 3'd3, 3'd0, {1'b0, shA});
      r = r << shA;
      outReg(3'd3, r);
      sendInstr(opShr, 3'd3, 3'd0, {1'b0, shB});
      r = r >> shB;
      outReg(3'd3, r);
      // Dependent chain with no gap
      loadReg(3'd5, c);
      loadReg(3'd6, d);
      sendInstr(opAdd, 3'd5, 3'd6, 5'd0);
      sendInstr(opInc, 3'd5, 3'd0, 5'd0);
      sendInstr(opShl, 3'd5, 3'd0, {1'b0, shA});
      sendInstr(opSub, 3'd5, 3'd6, 5'd0);
      sendInstr(opNot, 3'd5, 3'd0, 5'd0);
      r = ~((((c + d) + 16'd1) << shA) - d);
      outReg(3'd5, r);
      collectOutputs();
    end
  endtask

  task automatic movInTest();
    wordT v;
    wordT p;
    v = wordT'($random(seed));
    p = wordT'($random(seed));
    loadReg(3'd1, v);
    sendInstr(opMov, 3'd5, 3'd1, 5'd0);
    outReg(3'd5, v);
    inPort = p;
    sendInstr(opIn, 3'd6, 3'd0, 5'd0);
    outReg(3'd6, p);
    collectOutputs();
  endtask

  task automatic jumpTest();
    wordT t1;
    wordT t2;
    wordT t3;
    wordT x;
    t1 = wordT'($random(seed));
    t2 = wordT'($random(seed));
    t3 = wordT'($random(seed));
    x = wordT'($random(seed));
    loadReg(3'd1, t1);
    loadReg(3'd2, t2);
    loadReg(3'd3, t3);
    sendInstr(opSetc, 3'd0, 3'd0, 5'd0);
    sendInstr(opJc, 3'd1, 3'd0, 5'd0);
    branchExp.push_back(t1);
    sendInstr(opClrc, 3'd0, 3'd0, 5'd0);
    sendInstr(opJc, 3'd2, 3'd0, 5'd0);
    loadReg(3'd4, x);
    loadReg(3'd5, x);
    sendInstr(opSub, 3'd4, 3'd5, 5'd0);
    sendInstr(opJz, 3'd1, 3'd0, 5'd0);
    branchExp.push_back(t1);
    loadReg(3'd4, 16'h0003);
    loadReg(3'd5, 16'h0005);
    sendInstr(opSub, 3'd4, 3'd5, 5'd0);
    sendInstr(opJz, 3'd2, 3'd0, 5'd0);
    sendInstr(opJn, 3'd3, 3'd0, 5'd0);
    branchExp.push_back(t3);
    loadReg(3'd4, 16'h0005);
    loadReg(3'd5, 16'h0003);
    sendInstr(opSub, 3'd4, 3'd5, 5'd0);
    sendInstr(opJn, 3'd2, 3'd0, 5'd0);
    sendInstr(opJmp, 3'd2, 3'd0, 5'd0);
    branchExp.push_back(t2);
    // The OUT trails every branch pulse
    outReg(3'd1, t1);
    collectOutputs();
    compareBranches();
  endtask

  task automatic backPressureTest();
    wordT v[3];
    int cycles;
    cycles = 0;
    while (owedCredits != 0 && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (owedCredits != 0) begin
      reportTimeout("the consumer could not return its credits");
    end else begin
      holdCredits = 1'b1;
      foreach (v[k]) begin
        v[k] = wordT'($random(seed));
        loadReg(regIdxT'(k + 1), v[k]);
      end
      foreach (v[k]) begin
        outReg(regIdxT'(k + 1), v[k]);
      end
      waitForOutCount(2);
      // Window in which a third pulse would show up
      repeat (20) @(negedge clk);
      checkValue("outValid pulses with credits withheld", outSeen.size(), 2);
      holdCredits = 1'b0;
      collectOutputs();
    end
  endtask

  task automatic illegalTest();
    wordT v1;
    wordT v2;
    int illegalBase;
    int cycles;
    v1 = wordT'($random(seed));
    v2 = wordT'($random(seed));
    loadReg(3'd1, v1);
    loadReg(3'd2, v2);
    illegalBase = illegalCount;
    sendInstr(opPush, 3'd1, 3'd2, 5'd0);
    sendInstr(opCall, 3'd2, 3'd1, 5'd0);
    outReg(3'd1, v1);
    outReg(3'd2, v2);
    collectOutputs();
    checkValue("illegalOp pulses", illegalCount - illegalBase, 2);
    cycles = 0;
    while (creditsBack != wordsSent && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    checkValue("input credits returned", creditsBack, wordsSent);
  endtask

  initial begin
    reset = 1'b1;
    inValid = 1'b0;
    inWord = '0;
    inPort = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    ldmOutTest();
    aluTest();
    movInTest();
    jumpTest();
    backPressureTest();
    illegalTest();
    closeRun();
  end

endmodule

`default_nettype wire

// ==== verif/execCoreAsserts.sv ====
`default_nettype none

module execCoreAsserts #(
  parameter int OutCredits = 2
) (
  input logic                               clk,
  input logic                               reset,
  input logic [$clog2(OutCredits + 1)-1:0] outCreditCount,
  input logic                               outValid,
  input logic                               outCreditReturn,
  input logic                               branchValid,
  input logic                               illegalOp
);

  timeunit 1ns;
  timeprecision 100ps;

  // Credit count rebuilt from the port pulses alone
  int portCredits;

  always_ff @(posedge clk) begin
    if (reset) begin
      portCredits <= OutCredits;
    end else begin
      portCredits <= portCredits + int'(outCreditReturn) - int'(outValid);
    end
  end

  creditBound: assert property (
    @(posedge clk) disable iff (reset) outCreditCount <= OutCredits
  ) else $error("output credit count above its limit");

  noSendWithoutCredit: assert property (
    @(posedge clk) disable iff (reset) outValid |-> (portCredits > 0)
  ) else $error("outValid asserted with no output credit");

  // Registered pulses settle after the first reset edge
  quietDuringReset: assert property (
    @(posedge clk) (reset ##1 reset) |-> (!branchValid && !illegalOp)
  ) else $error("branchValid or illegalOp high during reset");

endmodule

`default_nettype wire

// ==== logic/execCore.sv ====
`default_nettype none

module execCore #(
  parameter int InDepth = 4,
  parameter int OutCredits = 2
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         inValid,
  input  cpuPkg::wordT inWord,
  output logic         inCreditReturn,
  output logic         outValid,
  output cpuPkg::wordT outWord,
  input  logic         outCreditReturn,
  input  cpuPkg::wordT inPort,
  output logic         branchValid,
  output cpuPkg::wordT branchTarget,
  output logic         illegalOp
);

  import cpuPkg::*;

  localparam int CreditW = $clog2(OutCredits + 1);

  wordT headWord;
  instrT headInstr;
  logic inNotEmpty;
  logic inPop;
  ctrlT ctrl;
  logic pendingImm;
  ctrlT ldmCtrl;
  regIdxT ldmDst;
  wordT regA;
  wordT regB;
  wordT fwdA;
  wordT fwdB;
  execT execNext;
  execT execReg;
  wordT aluResult;
  wordT wbData;
  logic wbEnable;
  flagsT aluFlags;
  flagsT flags;
  logic jumpCond;
  logic jumpTaken;
  logic outPush;
  logic outFull;
  logic outNotEmpty;
  logic outSend;
  logic [CreditW-1:0] outCreditCount;

  creditQueue #(.Depth(InDepth), .payloadT(wordT)) inQueue_inst (
    .clk, .reset, .push(inValid), .pushData(inWord), .pop(inPop),
    .headData(headWord), .notEmpty(inNotEmpty), .full()
  );

  assign headInstr = instrT'(headWord);

  // The word after LDM is data, so decode sees a bubble
  controlUnit controlUnit_inst (
    .opCode(headInstr.opCode), .makeMeBubble(pendingImm), .ctrl(ctrl)
  );

  // Two OUTs in a row could overrun the output queue
  assign inPop = inNotEmpty && !outFull &&
                 !(execReg.valid && execReg.ctrl.isOut && ctrl.isOut);

  registerFile registerFile_inst (
    .clk, .reset, .readA(headInstr.rDst), .readB(headInstr.rSrc),
    .dataA(regA), .dataB(regB), .writeEnable(wbEnable),
    .writeIdx(execReg.rDst), .writeData(wbData)
  );

  assign fwdA = (wbEnable && execReg.rDst == headInstr.rDst) ? wbData : regA;
  assign fwdB = (wbEnable && execReg.rDst == headInstr.rSrc) ? wbData : regB;

  always_comb begin
    execNext = '0;
    if (inPop && pendingImm) begin
      execNext.valid = 1'b1;
      execNext.ctrl = ldmCtrl;
      execNext.opCode = opLdm;
      execNext.rDst = ldmDst;
      execNext.opB = headWord;
    end else if (inPop && !ctrl.twoWord && !ctrl.isNop) begin
      execNext.valid = 1'b1;
      execNext.ctrl = ctrl;
      execNext.opCode = headInstr.opCode;
      execNext.rDst = headInstr.rDst;
      execNext.opA = fwdA;
      execNext.opB = ctrl.immOrReg ? fwdB : wordT'(headInstr.shamt);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pendingImm <= 1'b0;
      execReg <= '0;
    end else begin
      if (inPop) begin
        pendingImm <= ctrl.twoWord;
      end
      execReg <= execNext;
    end
  end

  always_ff @(posedge clk) begin
    if (inPop && ctrl.twoWord) begin
      ldmCtrl <= ctrl;
      ldmDst <= headInstr.rDst;
    end
  end

  aluUnit aluUnit_inst (
    .op(execReg.ctrl.aluControl), .a(execReg.opA), .b(execReg.opB),
    .carryIn(flags.carry), .result(aluResult), .flagsOut(aluFlags)
  );

  statusFlags statusFlags_inst (
    .clk, .reset, .update(execReg.valid && execReg.ctrl.updateStatus),
    .carryCtl(execReg.ctrl.carryFlag), .aluFlags, .flags
  );

  assign wbData = execReg.ctrl.isIn ? inPort : aluResult;
  assign wbEnable = execReg.valid && execReg.ctrl.regWrite;
  assign outPush = execReg.valid && execReg.ctrl.isOut;

  // Low opcode bits pick the flag, JMP falls through as always taken
  always_comb begin
    case (execReg.opCode[1:0])
      2'd0:    jumpCond = flags.zero;
      2'd1:    jumpCond = flags.negative;
      2'd2:    jumpCond = flags.carry;
      default: jumpCond = 1'b1;
    endcase
  end

  assign jumpTaken = execReg.valid && execReg.ctrl.isJump &&
                     (!execReg.ctrl.branchFlag || jumpCond);

  always_ff @(posedge clk) begin
    if (reset) begin
      inCreditReturn <= 1'b0;
      branchValid <= 1'b0;
      illegalOp <= 1'b0;
    end else begin
      inCreditReturn <= inPop;
      branchValid <= jumpTaken;
      illegalOp <= execReg.valid && execReg.ctrl.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (jumpTaken) begin
      branchTarget <= aluResult;
    end
  end

  creditQueue #(.Depth(OutCredits), .payloadT(wordT)) outQueue_inst (
    .clk, .reset, .push(outPush), .pushData(aluResult), .pop(outSend),
    .headData(outWord), .notEmpty(outNotEmpty), .full(outFull)
  );

  assign outSend = outNotEmpty && (outCreditCount != '0);
  assign outValid = outSend;

  always_ff @(posedge clk) begin
    if (reset) begin
      outCreditCount <= CreditW'(OutCredits);
    end else begin
      outCreditCount <= outCreditCount + CreditW'(outCreditReturn) - CreditW'(outSend);
    end
  end

endmodule

`default_nettype wire

// ==== logic/statusFlags.sv ====
`default_nettype none

module statusFlags (
  input  logic             clk,
  input  logic             reset,
  input  logic             update,
  input  cpuPkg::carryCtlT carryCtl,
  input  cpuPkg::flagsT    aluFlags,
  output cpuPkg::flagsT    flags
);

  import cpuPkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (update) begin
      case (carryCtl)
        carrySet:   flags.carry <= 1'b1;
        carryClear: flags.carry <= 1'b0;
        carryKeep:  flags <= aluFlags;
        // Nothing saved to restore from without interrupts
        carryRestore: flags <= flags;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
`default_nettype none

module aluUnit (
  input  cpuPkg::aluOpT op,
  input  cpuPkg::wordT  a,
  input  cpuPkg::wordT  b,
  input  logic          carryIn,
  output cpuPkg::wordT  result,
  output cpuPkg::flagsT flagsOut
);

  import cpuPkg::*;

  logic [16:0] addWide;
  logic [16:0] subWide;
  logic [16:0] incWide;
  logic [16:0] decWide;
  logic [16:0] shlWide;
  logic carryOut;

  assign addWide = {1'b0, a} + {1'b0, b};
  assign subWide = {1'b0, a} - {1'b0, b};
  assign incWide = {1'b0, a} + 17'd1;
  assign decWide = {1'b0, a} - 17'd1;
  // Bit 16 holds the last bit shifted out
  assign shlWide = {1'b0, a} << b[3:0];

  always_comb begin
    result = '0;
    carryOut = carryIn;
    case (op)
      aluAdd:   {carryOut, result} = addWide;
      aluSub:   {carryOut, result} = subWide;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluShl:   {carryOut, result} = shlWide;
      aluShr:   result = a >> b[3:0];
      aluNot:   result = ~a;
      aluPassB: result = b;
      aluInc:   {carryOut, result} = incWide;
      aluDec:   {carryOut, result} = decWide;
      aluPassA: result = a;
      default:  result = '0;
    endcase
  end

  assign flagsOut = '{zero: (result == '0), negative: result[15], carry: carryOut};

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile (
  input  logic           clk,
  input  logic           reset,
  input  cpuPkg::regIdxT readA,
  input  cpuPkg::regIdxT readB,
  output cpuPkg::wordT   dataA,
  output cpuPkg::wordT   dataB,
  input  logic           writeEnable,
  input  cpuPkg::regIdxT writeIdx,
  input  cpuPkg::wordT   writeData
);

  import cpuPkg::*;

  wordT regs [8];

  assign dataA = regs[readA];
  assign dataB = regs[readB];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeIdx] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`default_nettype none

module controlUnit (
  input  cpuPkg::opCodeT opCode,
  input  logic           makeMeBubble,
  output cpuPkg::ctrlT   ctrl
);

  import cpuPkg::*;

  always_comb begin
    ctrl = '0;
    ctrl.immOrReg = 1'b1;
    ctrl.aluControl = aluNone;
    ctrl.carryFlag = carryKeep;
    if (makeMeBubble) begin
      ctrl.immOrReg = 1'b0;
    end else begin
      case (opCode)
        opNop: begin
          ctrl.isNop = 1'b1;
        end
        opSetc: begin
          ctrl.updateStatus = 1'b1;
          ctrl.carryFlag = carrySet;
        end
        opClrc: begin
          ctrl.updateStatus = 1'b1;
          ctrl.carryFlag = carryClear;
        end
        opNot, opInc, opDec: begin
          ctrl.regWrite = 1'b1;
          ctrl.updateStatus = 1'b1;
          ctrl.aluControl = (opCode == opNot) ? aluNot :
                            (opCode == opInc) ? aluInc : aluDec;
        end
        opOut: begin
          ctrl.isOut = 1'b1;
          ctrl.aluControl = aluPassA;
        end
        opIn: begin
          ctrl.regWrite = 1'b1;
          ctrl.isIn = 1'b1;
          ctrl.aluControl = aluPassA;
        end
        opMov: begin
          // Source register arrives on operand B
          ctrl.regWrite = 1'b1;
          ctrl.aluControl = aluPassB;
        end
        opAdd, opSub, opAnd, opOr: begin
          ctrl.regWrite = 1'b1;
          ctrl.updateStatus = 1'b1;
          case (opCode)
            opAdd:   ctrl.aluControl = aluAdd;
            opSub:   ctrl.aluControl = aluSub;
            opAnd:   ctrl.aluControl = aluAnd;
            default: ctrl.aluControl = aluOr;
          endcase
        end
        opShl, opShr: begin
          ctrl.regWrite = 1'b1;
          ctrl.updateStatus = 1'b1;
          ctrl.immOrReg = 1'b0;
          ctrl.aluControl = (opCode == opShl) ? aluShl : aluShr;
        end
        opLdm: begin
          ctrl.regWrite = 1'b1;
          ctrl.immOrReg = 1'b0;
          ctrl.aluControl = aluPassB;
          ctrl.twoWord = 1'b1;
        end
        opJz, opJn, opJc: begin
          ctrl.isJump = 1'b1;
          ctrl.branchFlag = 1'b1;
          ctrl.aluControl = aluPassA;
        end
        opJmp: begin
          ctrl.isJump = 1'b1;
          ctrl.aluControl = aluPassA;
        end
        opPush, opPop, opLdd, opStd, opCall, opRet, opRti: begin
          ctrl.illegal = 1'b1;
        end
        // Second halves of call, return and interrupt sequences
        default: begin
          ctrl.illegal = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/creditQueue.sv ====
`default_nettype none

module creditQueue #(
  parameter int Depth = 4,
  parameter type payloadT = logic [15:0]
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT headData,
  output logic    notEmpty,
  output logic    full
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  payloadT mem [Depth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [CountW-1:0] count;
  logic doPush;
  logic doPop;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign notEmpty = (count != '0);
  assign full = (count == CountW'(Depth));
  assign headData = mem[rdPtr];

  assign doPop = pop && notEmpty;
  // A full queue still takes a word when its head leaves in the same cycle
  assign doPush = push && (!full || doPop);

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CountW'(doPush) - CountW'(doPop);
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  typedef logic [15:0] wordT;
  typedef logic [2:0] regIdxT;
  typedef logic [4:0] opCodeT;

  // Instruction word layout
  typedef struct packed {
    opCodeT opCode;
    regIdxT rDst;
    regIdxT rSrc;
    logic [4:0] shamt;
  } instrT;

  localparam opCodeT opNop  = 5'd0;
  localparam opCodeT opSetc = 5'd1;
  localparam opCodeT opClrc = 5'd2;
  localparam opCodeT opNot  = 5'd3;
  localparam opCodeT opInc  = 5'd4;
  localparam opCodeT opDec  = 5'd5;
  localparam opCodeT opOut  = 5'd6;
  localparam opCodeT opIn   = 5'd7;
  localparam opCodeT opMov  = 5'd8;
  localparam opCodeT opAdd  = 5'd9;
  localparam opCodeT opSub  = 5'd10;
  localparam opCodeT opAnd  = 5'd11;
  localparam opCodeT opOr   = 5'd12;
  localparam opCodeT opShl  = 5'd13;
  localparam opCodeT opShr  = 5'd14;
  localparam opCodeT opLdm  = 5'd17;
  localparam opCodeT opJz   = 5'd20;
  localparam opCodeT opJn   = 5'd21;
  localparam opCodeT opJc   = 5'd22;
  localparam opCodeT opJmp  = 5'd23;

  // Memory, stack and call opcodes with no datapath in this core
  localparam opCodeT opPush = 5'd15;
  localparam opCodeT opPop  = 5'd16;
  localparam opCodeT opLdd  = 5'd18;
  localparam opCodeT opStd  = 5'd19;
  localparam opCodeT opCall = 5'd24;
  localparam opCodeT opRet  = 5'd26;
  localparam opCodeT opRti  = 5'd28;

  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluAnd   = 4'd2,
    aluOr    = 4'd3,
    aluShl   = 4'd4,
    aluShr   = 4'd5,
    aluNot   = 4'd6,
    aluPassB = 4'd7,
    aluInc   = 4'd8,
    aluDec   = 4'd9,
    aluPassA = 4'd10,
    aluNone  = 4'd15
  } aluOpT;

  typedef enum logic [1:0] {
    carryKeep    = 2'd0,
    carryClear   = 2'd1,
    carryRestore = 2'd2,
    carrySet     = 2'd3
  } carryCtlT;

  typedef struct packed {
    logic regWrite;
    logic updateStatus;
    logic immOrReg;
    aluOpT aluControl;
    carryCtlT carryFlag;
    logic branchFlag;
    logic isJump;
    logic isOut;
    logic isIn;
    logic twoWord;
    logic illegal;
    logic isNop;
  } ctrlT;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } flagsT;

  // Decode to execute register
  typedef struct packed {
    logic valid;
    ctrlT ctrl;
    opCodeT opCode;
    regIdxT rDst;
    wordT opA;
    wordT opB;
  } execT;

endpackage

`default_nettype wire
